/* hdl/bif_pkg.sv */
// Shared cycle kind, status and phase types plus bus timing constants
package bif_pkg;

   // Kind of bus cycle carried from requester to the bus strobes
   typedef enum logic [1:0] {
      KIND_MEM = 2'd0,  // Memory read or write
      KIND_IO  = 2'd1,  // IO read or write
      KIND_SEM = 2'd2,  // Semaphore read, a memory cycle with semrq_n
      KIND_REF = 2'd3   // Refresh cycle from the refresh requester
   } bif_kind_t;

   // Result reported with done or ref_done
   typedef enum logic [1:0] {
      STAT_OK          = 2'd0,  // Responder answered with bdry_n
      STAT_TIMEOUT_MEM = 2'd1,  // No answer on a memory side cycle, berror_n goes low
      STAT_TIMEOUT_IO  = 2'd2   // No answer on an IO cycle, ioxerr_n goes low
   } bif_status_t;

   // Sequencer phase, decoded straight into bus strobes by the driver
   typedef enum logic [1:0] {
      PH_IDLE = 2'd0,
      PH_ADDR = 2'd1,  // One cycle with apr_n low
      PH_DATA = 2'd2,  // Runs until ready or timeout
      PH_DONE = 2'd3   // One cycle, completion pulse and error lines
   } bif_phase_t;

   // Data phase cycles without ready before the cycle is given up
   localparam int TIMEOUT_CYCLES = 16;

   // Width of the data phase counter, wide enough to hold TIMEOUT_CYCLES
   localparam int TOUT_W = 5;

endpackage

/* hdl/bif_arbiter.sv */
// Registered fixed priority arbiter for refresh and CPU cycles with grant chain pass-through
module bif_arbiter (
   input  logic               clk,
   input  logic               rst,
   input  logic               cpu_req,      // Level, held until done
   input  bif_pkg::bif_kind_t cpu_kind,
   input  logic               cpu_write,
   input  logic               ref_req,      // Level, held until ref_done
   input  logic               busy,         // Sequencer owns the bus
   input  logic               grant_in_n,   // Grant from upstream
   output logic               start,        // One cycle launch pulse
   output bif_pkg::bif_kind_t start_kind,
   output logic               start_write,
   output logic               out_grant_n   // Grant to the next unit down the chain
);

   logic cpu_hold;   // CPU request already served, wait for it to drop
   logic ref_hold;   // Same for the refresh requester
   logic cpu_pend;
   logic ref_pend;
   logic can_start;

   assign cpu_pend  = cpu_req && !cpu_hold;
   assign ref_pend  = ref_req && !ref_hold;

   // A start still in flight has not yet raised busy, so it blocks a second launch
   assign can_start = !busy && !start;

   always_ff @(posedge clk) begin
      if (rst) begin
         start    <= 1'b0;
         cpu_hold <= 1'b0;
         ref_hold <= 1'b0;
      end else begin
         start <= can_start && (ref_pend || cpu_pend);

         // The requester keeps its level through done, so marking it at launch
         // keeps the same request from being launched twice
         if (can_start && ref_pend) begin
            ref_hold <= 1'b1;
         end else if (!ref_req) begin
            ref_hold <= 1'b0;   // Released once the request is withdrawn
         end

         if (can_start && !ref_pend && cpu_pend) begin
            cpu_hold <= 1'b1;   // CPU only wins with no refresh pending
         end else if (!cpu_req) begin
            cpu_hold <= 1'b0;
         end
      end
   end

   // Cycle descriptor, only meaningful together with start
   always_ff @(posedge clk) begin
      if (can_start) begin
         if (ref_pend) begin
            start_kind  <= bif_pkg::KIND_REF;
            start_write <= 1'b0;           // Refresh never writes
         end else begin
            start_kind  <= cpu_kind;
            start_write <= cpu_write;
         end
      end
   end

   // Grant ripples on only when this unit neither wants nor holds the bus
   assign out_grant_n = (cpu_req || ref_req || start || busy) ? 1'b1 : grant_in_n;

   // A launch must never overlap a running cycle in the sequencer
   a_no_start_busy : assert property (@(posedge clk) disable iff (rst) !(start && busy))
      else $error("Start issued while the sequencer is busy");

endmodule

/* hdl/bif_cycle_ctl.sv */
// Bus cycle sequencer with address and data phases, ready wait, timeout and status
module bif_cycle_ctl (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 start,        // Launch pulse from the arbiter
   input  bif_pkg::bif_kind_t   start_kind,
   input  logic                 start_write,
   input  logic                 bdry_n,       // Responder ready, active low
   output bif_pkg::bif_phase_t  phase,
   output bif_pkg::bif_kind_t   cyc_kind,     // Kind of the running cycle
   output logic                 cyc_write,
   output logic                 timed_out,    // Running cycle ended without ready
   output logic                 busy,
   output logic                 done,         // CPU completion pulse
   output logic                 ref_done,     // Refresh completion pulse
   output bif_pkg::bif_status_t status        // Valid with done or ref_done
);

   logic [bif_pkg::TOUT_W-1:0] tout_cnt;   // Data phase cycles seen so far
   logic                       tout_last;  // Final data phase cycle before timeout
   bif_pkg::bif_status_t       tout_stat;

   assign tout_last = (tout_cnt == bif_pkg::TOUT_W'(bif_pkg::TIMEOUT_CYCLES - 1));

   // IO timeouts get their own code, everything else counts as a memory side error
   assign tout_stat = (cyc_kind == bif_pkg::KIND_IO) ? bif_pkg::STAT_TIMEOUT_IO
                                                     : bif_pkg::STAT_TIMEOUT_MEM;

   assign busy = (phase != bif_pkg::PH_IDLE);

   always_ff @(posedge clk) begin
      if (rst) begin
         phase     <= bif_pkg::PH_IDLE;
         timed_out <= 1'b0;
         done      <= 1'b0;
         ref_done  <= 1'b0;
         status    <= bif_pkg::STAT_OK;
         tout_cnt  <= '0;
      end else begin
         case (phase)
            bif_pkg::PH_IDLE: begin
               if (start) begin
                  phase     <= bif_pkg::PH_ADDR;
                  timed_out <= 1'b0;   // Clear the previous cycle's error
               end
            end
            bif_pkg::PH_ADDR: begin
               phase    <= bif_pkg::PH_DATA;   // Address phase is always one cycle
               tout_cnt <= '0;
            end
            bif_pkg::PH_DATA: begin
               if (!bdry_n) begin
                  phase    <= bif_pkg::PH_DONE;
                  status   <= bif_pkg::STAT_OK;
                  done     <= (cyc_kind != bif_pkg::KIND_REF);
                  ref_done <= (cyc_kind == bif_pkg::KIND_REF);
               end else if (tout_last) begin
                  // Nobody answered, give up and flag the error for the driver
                  phase     <= bif_pkg::PH_DONE;
                  timed_out <= 1'b1;
                  status    <= tout_stat;
                  done      <= (cyc_kind != bif_pkg::KIND_REF);
                  ref_done  <= (cyc_kind == bif_pkg::KIND_REF);
               end else begin
                  tout_cnt <= tout_cnt + bif_pkg::TOUT_W'(1);
               end
            end
            default: begin   // PH_DONE
               phase    <= bif_pkg::PH_IDLE;
               done     <= 1'b0;   // Pulses last exactly the done cycle
               ref_done <= 1'b0;
            end
         endcase
      end
   end

   // Descriptor is captured once per cycle and held until the next start
   always_ff @(posedge clk) begin
      if (start && phase == bif_pkg::PH_IDLE) begin
         cyc_kind  <= start_kind;
         cyc_write <= start_write;
      end
   end

   // A start that reaches a running cycle would be lost, so each one must open an address phase
   a_start_opens_addr : assert property (@(posedge clk) disable iff (rst)
      start |=> (phase == bif_pkg::PH_ADDR))
      else $error("Start did not open an address phase");

   // Completion goes to exactly one requester
   a_one_done : assert property (@(posedge clk) disable iff (rst) !(done && ref_done))
      else $error("done and ref_done asserted together");

endmodule

/* hdl/bif_bdrv.sv */
// Combinational bus driver forming active low strobes, semaphore request and error lines
module bif_bdrv (
   input  bif_pkg::bif_phase_t phase,
   input  bif_pkg::bif_kind_t  cyc_kind,
   input  logic                cyc_write,
   input  logic                timed_out,
   output logic                apr_n,     // Address present
   output logic                dap_n,     // Data present
   output logic                mem_n,     // Memory and semaphore cycles
   output logic                ref_n,     // Refresh cycle
   output logic                iod_n,     // IO cycle
   output logic                write_n,
   output logic                semrq_n,   // Semaphore request
   output logic                berror_n,  // Memory side bus error
   output logic                ioxerr_n   // IO transfer error
);

   logic active;     // Address or data phase, strobes enabled
   logic kind_mem;   // Semaphore reads go out as memory cycles
   logic kind_io;
   logic kind_ref;
   logic kind_sem;
   logic err_en;     // Error lines enabled only in the done phase of a timed out cycle

   assign active   = (phase == bif_pkg::PH_ADDR) || (phase == bif_pkg::PH_DATA);
   assign kind_sem = (cyc_kind == bif_pkg::KIND_SEM);
   assign kind_mem = (cyc_kind == bif_pkg::KIND_MEM) || kind_sem;
   assign kind_io  = (cyc_kind == bif_pkg::KIND_IO);
   assign kind_ref = (cyc_kind == bif_pkg::KIND_REF);
   assign err_en   = (phase == bif_pkg::PH_DONE) && timed_out;

   assign apr_n = !(phase == bif_pkg::PH_ADDR);
   assign dap_n = !(phase == bif_pkg::PH_DATA);

   // Kind strobes cover both phases of the cycle
   assign mem_n = !(active && kind_mem);
   assign iod_n = !(active && kind_io);
   assign ref_n = !(active && kind_ref);

   // Only plain memory and IO cycles may write
   assign write_n = !(active && cyc_write &&
                      (cyc_kind == bif_pkg::KIND_MEM || kind_io));

   assign semrq_n = !(active && kind_sem);

   assign berror_n = !(err_en && kind_mem);  // Refresh timeouts stay off the error lines
   assign ioxerr_n = !(err_en && kind_io);

   // Strobes are decoded from one kind field, so two of them low means a broken decode
   always_comb begin
      assert ({1'b0, !mem_n} + {1'b0, !iod_n} + {1'b0, !ref_n} <= 2'd1)
         else $error("More than one kind strobe active");
   end

endmodule

/* hdl/bif_top.sv */
// Bus interface controller top joining arbiter, cycle sequencer and bus driver
module bif_top (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cpu_req,
   input  bif_pkg::bif_kind_t   cpu_kind,
   input  logic                 cpu_write,
   input  logic                 ref_req,
   input  logic                 grant_in_n,
   input  logic                 bdry_n,
   output logic                 done,
   output logic                 ref_done,
   output bif_pkg::bif_status_t status,
   output logic                 out_grant_n,
   output logic                 apr_n,
   output logic                 dap_n,
   output logic                 mem_n,
   output logic                 ref_n,
   output logic                 iod_n,
   output logic                 write_n,
   output logic                 semrq_n,
   output logic                 berror_n,
   output logic                 ioxerr_n
);

   logic                start;        // Arbiter launch into the sequencer
   bif_pkg::bif_kind_t  start_kind;
   logic                start_write;
   logic                busy;
   bif_pkg::bif_phase_t phase;        // Sequencer state seen by the driver
   bif_pkg::bif_kind_t  cyc_kind;
   logic                cyc_write;
   logic                timed_out;

   bif_arbiter u_arb (
      .clk         (clk),
      .rst         (rst),
      .cpu_req     (cpu_req),
      .cpu_kind    (cpu_kind),
      .cpu_write   (cpu_write),
      .ref_req     (ref_req),
      .busy        (busy),
      .grant_in_n  (grant_in_n),
      .start       (start),
      .start_kind  (start_kind),
      .start_write (start_write),
      .out_grant_n (out_grant_n)
   );

   bif_cycle_ctl u_cyc (
      .clk         (clk),
      .rst         (rst),
      .start       (start),
      .start_kind  (start_kind),
      .start_write (start_write),
      .bdry_n      (bdry_n),
      .phase       (phase),
      .cyc_kind    (cyc_kind),
      .cyc_write   (cyc_write),
      .timed_out   (timed_out),
      .busy        (busy),
      .done        (done),
      .ref_done    (ref_done),
      .status      (status)
   );

   bif_bdrv u_drv (
      .phase     (phase),
      .cyc_kind  (cyc_kind),
      .cyc_write (cyc_write),
      .timed_out (timed_out),
      .apr_n     (apr_n),
      .dap_n     (dap_n),
      .mem_n     (mem_n),
      .ref_n     (ref_n),
      .iod_n     (iod_n),
      .write_n   (write_n),
      .semrq_n   (semrq_n),
      .berror_n  (berror_n),
      .ioxerr_n  (ioxerr_n)
   );

endmodule

/* testbench/tb_bif.sv */
// Testbench for the bus interface controller with responder model, reference status and watchdog
module tb_bif;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_NS       = 4;
   localparam int RESET_CYCLES = 8;
   localparam int NUM_CYCLES   = 13;   // Bus cycles launched by the stimulus below
   localparam int WATCHDOG_NS  = NUM_CYCLES * (bif_pkg::TIMEOUT_CYCLES + 4) * CLK_NS
                                 + RESET_CYCLES * CLK_NS;

   logic                 clk;
   logic                 rst;
   logic                 cpu_req;
   bif_pkg::bif_kind_t   cpu_kind;
   logic                 cpu_write;
   logic                 ref_req;
   logic                 grant_in_n;
   logic                 bdry_n;
   logic                 done;
   logic                 ref_done;
   bif_pkg::bif_status_t status;
   logic                 out_grant_n;
   logic                 apr_n;
   logic                 dap_n;
   logic                 mem_n;
   logic                 ref_n;
   logic                 iod_n;
   logic                 write_n;
   logic                 semrq_n;
   logic                 berror_n;
   logic                 ioxerr_n;

   integer               seed = 82608;
   int                   resp_delay;    // Data phase cycles before the responder answers
   int                   done_count;    // Completion pulses seen by the compare process
   string                cur_name;      // Test running now, used in error lines
   bif_pkg::bif_kind_t   cur_kind;
   bif_pkg::bif_status_t exp_status;

   bif_top DUT (.*);

   always #(CLK_NS / 2) clk = !clk;

   // Responder answers a set number of clocks into the data phase, or stays silent
   always begin
      @(negedge dap_n);
      if (resp_delay < bif_pkg::TIMEOUT_CYCLES) begin
         repeat (resp_delay) @(posedge clk);
         #1 bdry_n = 1'b0;
      end
      @(posedge dap_n);
      #1 bdry_n = 1'b1;   // Release once the data phase is over
   end

   // Status follows from the responder delay alone, IO gets its own timeout code
   function automatic bif_pkg::bif_status_t expected_status(input bif_pkg::bif_kind_t kind,
                                                            input int delay);
      if (delay < bif_pkg::TIMEOUT_CYCLES) begin
         return bif_pkg::STAT_OK;
      end else if (kind == bif_pkg::KIND_IO) begin
         return bif_pkg::STAT_TIMEOUT_IO;
      end else begin
         return bif_pkg::STAT_TIMEOUT_MEM;
      end
   endfunction

   function automatic int random_delay();
      int r;
      r = $random(seed) & 32'h7fff_ffff;   // Keep it positive before the modulo
      return r % bif_pkg::TIMEOUT_CYCLES;
   endfunction

   task automatic check_status(input string name, input bif_pkg::bif_status_t exp,
                               input bif_pkg::bif_status_t act);
      if (exp !== act) begin
         $display("ERR %s: expected %s, actual %s", name, exp.name(), act.name());
         $display("FAIL: see errors above");
         $fatal(1, "Status mismatch in %s", name);
      end
   endtask

   task automatic check_line(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("ERR %s: expected %b, actual %b", name, exp, act);
         $display("FAIL: see errors above");
         $fatal(1, "Line mismatch in %s", name);
      end
   endtask

   // Kind strobes, write and semaphore request, all low only while on is set
   task automatic check_strobes(input string name, input bif_pkg::bif_kind_t kind,
                                input logic write, input logic on);
      check_line({name, " mem_n"}, !(on && (kind == bif_pkg::KIND_MEM ||
                                            kind == bif_pkg::KIND_SEM)), mem_n);
      check_line({name, " iod_n"}, !(on && kind == bif_pkg::KIND_IO), iod_n);
      check_line({name, " ref_n"}, !(on && kind == bif_pkg::KIND_REF), ref_n);
      check_line({name, " write_n"}, !(on && write && (kind == bif_pkg::KIND_MEM ||
                                                        kind == bif_pkg::KIND_IO)), write_n);
      check_line({name, " semrq_n"}, !(on && kind == bif_pkg::KIND_SEM), semrq_n);
   endtask

   // Follows one cycle from a request raised just after a rising edge up to its completion
   task automatic follow_cycle(input string name, input bif_pkg::bif_kind_t kind,
                               input logic write, input int delay);
      cur_name   = name;
      cur_kind   = kind;
      resp_delay = delay;
      exp_status = expected_status(kind, delay);
      @(negedge clk);   // Request not yet sampled by the arbiter
      check_line({name, " apr_n before start"}, 1'b1, apr_n);
      check_line({name, " out_grant_n pending"}, 1'b1, out_grant_n);
      @(negedge clk);   // Start pulse cycle
      check_line({name, " apr_n at start"}, 1'b1, apr_n);
      @(negedge clk);   // Two cycles after the request
      check_line({name, " apr_n in address phase"}, 1'b0, apr_n);
      check_line({name, " dap_n in address phase"}, 1'b1, dap_n);
      check_strobes({name, " address phase"}, kind, write, 1'b1);
      @(negedge clk);
      check_line({name, " apr_n in data phase"}, 1'b1, apr_n);
      check_line({name, " dap_n in data phase"}, 1'b0, dap_n);
      @(negedge clk);
      while (!done && !ref_done) begin
         check_line({name, " dap_n held"}, 1'b0, dap_n);
         check_strobes({name, " data phase"}, kind, write, 1'b1);
         check_line({name, " out_grant_n busy"}, 1'b1, out_grant_n);
         @(negedge clk);
      end
      check_line({name, " done"}, kind != bif_pkg::KIND_REF, done);
      check_line({name, " ref_done"}, kind == bif_pkg::KIND_REF, ref_done);
      check_line({name, " dap_n at done"}, 1'b1, dap_n);
      check_strobes({name, " done phase"}, kind, write, 1'b0);
      check_line({name, " out_grant_n at done"}, 1'b1, out_grant_n);
   endtask

   task automatic run_cpu(input string name, input bif_pkg::bif_kind_t kind,
                          input logic write, input int delay);
      @(posedge clk);
      #1;
      cpu_req   = 1'b1;
      cpu_kind  = kind;
      cpu_write = write;
      follow_cycle(name, kind, write, delay);
      @(posedge clk);
      #1 cpu_req = 1'b0;   // Requester lets go the cycle after done
      @(negedge clk);
      check_line({name, " out_grant_n idle"}, 1'b0, out_grant_n);
   endtask

   // Compares status and error lines at every completion pulse
   always @(negedge clk) begin
      if (!rst && (done || ref_done)) begin
         check_status({cur_name, " status"}, exp_status, status);
         check_line({cur_name, " berror_n"}, !(exp_status == bif_pkg::STAT_TIMEOUT_MEM &&
                                               cur_kind != bif_pkg::KIND_REF), berror_n);
         check_line({cur_name, " ioxerr_n"}, !(exp_status == bif_pkg::STAT_TIMEOUT_IO),
                    ioxerr_n);
         done_count = done_count + 1;
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before all bus cycles completed");
      $display("FAIL: see errors above");
      $fatal(1, "Watchdog timeout");
   end

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      cpu_req    = 1'b0;
      cpu_kind   = bif_pkg::KIND_MEM;
      cpu_write  = 1'b0;
      ref_req    = 1'b0;
      grant_in_n = 1'b1;
      bdry_n     = 1'b1;
      resp_delay = 0;
      done_count = 0;
      cur_name   = "reset";
      cur_kind   = bif_pkg::KIND_MEM;
      exp_status = bif_pkg::STAT_OK;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst = 1'b0;
      @(negedge clk);
      check_line("reset apr_n", 1'b1, apr_n);
      check_line("reset dap_n", 1'b1, dap_n);
      check_strobes("reset", bif_pkg::KIND_MEM, 1'b0, 1'b0);
      check_line("reset berror_n", 1'b1, berror_n);
      check_line("reset ioxerr_n", 1'b1, ioxerr_n);
      check_line("reset out_grant_n", 1'b1, out_grant_n);
      check_line("reset done", 1'b0, done);
      check_line("reset ref_done", 1'b0, ref_done);

      @(posedge clk);
      #1 grant_in_n = 1'b0;   // Upstream grant arrives while idle
      @(negedge clk);
      check_line("grant pass idle", 1'b0, out_grant_n);

      for (int i = 0; i < 6; i++) begin
         run_cpu((i % 2 == 1) ? "mem write" : "mem read", bif_pkg::KIND_MEM, i % 2 == 1,
                 random_delay());
      end
      run_cpu("io write", bif_pkg::KIND_IO, 1'b1, random_delay());
      run_cpu("io read", bif_pkg::KIND_IO, 1'b0, random_delay());
      run_cpu("io timeout", bif_pkg::KIND_IO, 1'b0, bif_pkg::TIMEOUT_CYCLES);
      run_cpu("mem timeout", bif_pkg::KIND_MEM, 1'b1, bif_pkg::TIMEOUT_CYCLES + 3);
      run_cpu("sem read", bif_pkg::KIND_SEM, 1'b1, random_delay());  // Write flag is ignored

      // Both requesters in one cycle, refresh has priority
      @(posedge clk);
      #1;
      ref_req   = 1'b1;
      cpu_req   = 1'b1;
      cpu_kind  = bif_pkg::KIND_MEM;
      cpu_write = 1'b1;
      follow_cycle("refresh first", bif_pkg::KIND_REF, 1'b0, 2);
      @(posedge clk);
      #1 ref_req = 1'b0;
      follow_cycle("cpu after refresh", bif_pkg::KIND_MEM, 1'b1, 3);
      @(posedge clk);
      #1 cpu_req = 1'b0;
      @(negedge clk);
      check_line("grant pass after refresh", 1'b0, out_grant_n);

      @(negedge clk);
      if (done_count == NUM_CYCLES) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         $display("Saw %0d completions for %0d launched cycles", done_count, NUM_CYCLES);
         $display("FAIL: see errors above");
         $fatal(1, "Completion count mismatch");
      end
   end

endmodule

/* all.f */
hdl/bif_pkg.sv
hdl/bif_arbiter.sv
hdl/bif_cycle_ctl.sv
hdl/bif_bdrv.sv
hdl/bif_top.sv
testbench/tb_bif.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the bus interface controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --timescale 1ns/100ps \
   --top-module tb_bif \
   -f all.f \
   -o tb_bif_sim

./obj_dir/tb_bif_sim
